// ==== u1e_defs.svh ====
`ifndef U1E_DEFS_SVH
`define U1E_DEFS_SVH

// Wishbone bus geometry
`define U1E_DW        16
`define U1E_AW        11
`define U1E_SW        2
`define U1E_DECODE_W  4    // Slave field, adr[10:7]
`define U1E_NSLAVES   3

// Misc block offsets
`define REG_LEDS      7'd0
`define REG_SWITCHES  7'd2
`define REG_CGEN_CTRL 7'd4
`define REG_CGEN_ST   7'd6
`define REG_TEST      7'd8

`define MISC_DEFAULT  16'hBEEF

`endif

// ==== u1e_pkg.sv ====
package u1e_pkg;

`include "u1e_defs.svh"

   // Plain decode view, slave field then byte offset
   typedef struct packed
   {
      logic [`U1E_DECODE_W-1:0]         slave;
      logic [`U1E_AW-`U1E_DECODE_W-1:0] offset;
   } wb_dec_t;

   // Settings bus view of the same word
   typedef struct packed
   {
      logic [`U1E_DECODE_W-1:0]           slave;
      logic [`U1E_AW-`U1E_DECODE_W-3:0]   reg_idx;   // 32 settings regs
      logic                               half;      // 0 low word, 1 high word
      logic                               byte_bit;  // Always 0 on 16-bit bus
   } wb_set_t;

   //////////////////////////////////////////////////
   // One bus address, two decodings
   //////////////////////////////////////////////////

   typedef union packed
   {
      wb_dec_t dec;
      wb_set_t set;
   } wb_addr_u;

endpackage

// ==== wb_if.sv ====
`timescale 1ns/1ns

`include "u1e_defs.svh"

interface wb_if;
   import u1e_pkg::*;

   wb_addr_u              adr;
   logic [`U1E_DW-1:0]    dat_mosi;   // Master to slave
   logic [`U1E_DW-1:0]    dat_miso;   // Slave to master
   logic [`U1E_SW-1:0]    sel;
   logic                  we;
   logic                  cyc;
   logic                  stb;
   logic                  ack;

   modport master
   (
      output adr, dat_mosi, sel, we, cyc, stb,
      input  dat_miso, ack
   );

   // Mirror of the master side
   modport slave
   (
      input  adr, dat_mosi, sel, we, cyc, stb,
      output dat_miso, ack
   );

endinterface

// ==== wb_1master.sv ====
`timescale 1ns/1ns

`include "u1e_defs.svh"

module wb_1master
(
   input logic  wb_clk,
   input logic  wb_rst,
   wb_if.slave  m,
   wb_if.master s0,
   wb_if.master s1,
   wb_if.master s2
);
   import u1e_pkg::*;

   logic [`U1E_NSLAVES-1:0] hit;
   logic                    unmapped;
   logic                    ack_unmapped;

   // Slave select from adr[10:7]
   assign hit[0]   = (m.adr.dec.slave == 4'd0);
   assign hit[1]   = (m.adr.dec.slave == 4'd1);
   assign hit[2]   = (m.adr.dec.slave == 4'd2);
   assign unmapped = ~|hit;

   //////////////////////////////////////////////////
   // Master to slaves
   //////////////////////////////////////////////////

   assign s0.adr      = m.adr;
   assign s0.dat_mosi = m.dat_mosi;
   assign s0.sel      = m.sel;
   assign s0.we       = m.we;
   assign s0.cyc      = m.cyc & hit[0];
   assign s0.stb      = m.stb & hit[0];

   assign s1.adr      = m.adr;
   assign s1.dat_mosi = m.dat_mosi;
   assign s1.sel      = m.sel;
   assign s1.we       = m.we;
   assign s1.cyc      = m.cyc & hit[1];
   assign s1.stb      = m.stb & hit[1];

   assign s2.adr      = m.adr;
   assign s2.dat_mosi = m.dat_mosi;
   assign s2.sel      = m.sel;
   assign s2.we       = m.we;
   assign s2.cyc      = m.cyc & hit[2];
   assign s2.stb      = m.stb & hit[2];

   //////////////////////////////////////////////////
   // Slaves to master
   //////////////////////////////////////////////////

   // Empty slots answer here so the bus never hangs
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_unmapped <= 1'b0;
      else
         ack_unmapped <= m.cyc & m.stb & unmapped & ~ack_unmapped;
   end

   always_comb
   begin
      m.dat_miso = '0;            // Read data zero when unmapped
      m.ack      = ack_unmapped;
      if (hit[0])
      begin
         m.dat_miso = s0.dat_miso;
         m.ack      = s0.ack;
      end
      else if (hit[1])
      begin
         m.dat_miso = s1.dat_miso;
         m.ack      = s1.ack;
      end
      else if (hit[2])
      begin
         m.dat_miso = s2.dat_miso;
         m.ack      = s2.ack;
      end
   end

endmodule

// ==== misc_regs.sv ====
`timescale 1ns/1ns

`include "u1e_defs.svh"

module misc_regs
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   wb_if.slave        bus,
   input  logic [2:0] debug_pb_i,
   input  logic [7:0] dip_sw_i,
   input  logic       cgen_st_status_i,
   input  logic       cgen_st_ld_i,
   input  logic       cgen_st_refmon_i,
   output logic [2:0] debug_led_o,
   output logic       cgen_sync_b_o,
   output logic       cgen_ref_sel_o,
   output logic       tx_underrun_o,
   output logic       rx_overrun_o
);
   import u1e_pkg::*;

   logic [`U1E_DW-1:0] leds;
   logic [`U1E_DW-1:0] cgen_ctrl;
   logic [`U1E_DW-1:0] test;
   logic               req;

   assign req = bus.cyc & bus.stb & ~bus.ack;   // New access this cycle

   //////////////////////////////////////////////////
   // Register writes and ack
   //////////////////////////////////////////////////

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         bus.ack   <= 1'b0;
         leds      <= '0;
         cgen_ctrl <= 16'd3;   // Sync_b and ref_sel high out of reset
         test      <= '0;
      end
      else
      begin
         bus.ack <= req;
         if (req & bus.we)
            case (bus.adr.dec.offset)
               `REG_LEDS:      leds      <= bus.dat_mosi;
               `REG_CGEN_CTRL: cgen_ctrl <= bus.dat_mosi;
               `REG_TEST:      test      <= bus.dat_mosi;
               default:        ;        // Read-only or unused offsets
            endcase
      end
   end

   // Readback
   always_comb
   begin
      case (bus.adr.dec.offset)
         `REG_LEDS:      bus.dat_miso = leds;
         `REG_SWITCHES:  bus.dat_miso = {5'b0, debug_pb_i, dip_sw_i};
         `REG_CGEN_CTRL: bus.dat_miso = cgen_ctrl;
         `REG_CGEN_ST:
            bus.dat_miso = {13'b0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         `REG_TEST:      bus.dat_miso = test;
         default:        bus.dat_miso = `MISC_DEFAULT;
      endcase
   end

   // Board LEDs are not wired in bit order
   assign {debug_led_o[2], debug_led_o[0], debug_led_o[1]} = leds[2:0];

   assign {cgen_sync_b_o, cgen_ref_sel_o} = cgen_ctrl[1:0];
   assign {rx_overrun_o, tx_underrun_o}   = test[1:0];

endmodule

// ==== settings_bus_16le.sv ====
`timescale 1ns/1ns

`include "u1e_defs.svh"

module settings_bus_16le
(
   input  logic        wb_clk,
   input  logic        wb_rst,
   wb_if.slave         bus,
   output logic        set_stb_o,
   output logic [7:0]  set_addr_o,
   output logic [31:0] set_data_o
);
   import u1e_pkg::*;

   logic [`U1E_DW-1:0] low_half;   // Held until the high half arrives
   logic               req;
   logic               wr;

   assign req = bus.cyc & bus.stb & ~bus.ack;
   assign wr  = req & bus.we;

   //////////////////////////////////////////////////
   // Two 16-bit writes make one setting
   //////////////////////////////////////////////////

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         bus.ack    <= 1'b0;
         low_half   <= '0;
         set_stb_o  <= 1'b0;
         set_addr_o <= '0;
         set_data_o <= '0;
      end
      else
      begin
         bus.ack   <= req;
         set_stb_o <= wr & bus.adr.set.half;   // Lines up with ack
         if (wr)
         begin
            if (!bus.adr.set.half)
               low_half <= bus.dat_mosi;
            else
            begin
               set_addr_o <= {3'b000, bus.adr.set.reg_idx};
               set_data_o <= {bus.dat_mosi, low_half};
            end
         end
      end
   end

   // Write only slave
   assign bus.dat_miso = '0;

endmodule

// ==== atr_controller16.sv ====
`timescale 1ns/1ns

`include "u1e_defs.svh"

module atr_controller16
(
   input  logic        wb_clk,
   input  logic        wb_rst,
   wb_if.slave         bus,
   input  logic        run_rx_i,
   input  logic        run_tx_i,
   output logic [15:0] ctrl_lines_o
);
   import u1e_pkg::*;

   // Idle, rx only, tx only, full duplex
   logic [`U1E_DW-1:0] state_words [4];
   logic [1:0]         wr_idx;
   logic               in_range;
   logic               req;
   logic [1:0]         run_state;

   assign wr_idx    = bus.adr.dec.offset[2:1];           // Offsets 0, 2, 4, 6
   assign in_range  = (bus.adr.dec.offset[6:3] == 4'd0);
   assign req       = bus.cyc & bus.stb & ~bus.ack;
   assign run_state = {run_tx_i, run_rx_i};

   //////////////////////////////////////////////////
   // State word registers
   //////////////////////////////////////////////////

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         bus.ack <= 1'b0;
         for (int i = 0; i < 4; i++)
            state_words[i] <= '0;
      end
      else
      begin
         bus.ack <= req;
         if (req & bus.we & in_range)
         begin
            if (bus.sel[1])
               state_words[wr_idx][15:8] <= bus.dat_mosi[15:8];
            if (bus.sel[0])
               state_words[wr_idx][7:0]  <= bus.dat_mosi[7:0];
         end
      end
   end

   assign bus.dat_miso = in_range ? state_words[wr_idx] : '0;

   // Output lines follow run state one clock later
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ctrl_lines_o <= '0;
      else
         ctrl_lines_o <= state_words[run_state];
   end

endmodule

// ==== u1e_core.sv ====
`timescale 1ns/1ns

`include "u1e_defs.svh"

module u1e_core
(
   input  logic                  wb_clk,
   input  logic                  wb_rst,

   // Wishbone master side, from the memory bridge
   input  logic [`U1E_AW-1:0]    m_adr_i,
   input  logic [`U1E_DW-1:0]    m_dat_i,
   output logic [`U1E_DW-1:0]    m_dat_o,
   input  logic [`U1E_SW-1:0]    m_sel_i,
   input  logic                  m_we_i,
   input  logic                  m_cyc_i,
   input  logic                  m_stb_i,
   output logic                  m_ack_o,

   input  logic [2:0]            debug_pb_i,
   input  logic [7:0]            dip_sw_i,
   input  logic                  cgen_st_status_i,
   input  logic                  cgen_st_ld_i,
   input  logic                  cgen_st_refmon_i,
   output logic [2:0]            debug_led_o,
   output logic                  cgen_sync_b_o,
   output logic                  cgen_ref_sel_o,
   output logic                  tx_underrun_o,
   output logic                  rx_overrun_o,

   output logic                  set_stb_o,
   output logic [7:0]            set_addr_o,
   output logic [31:0]           set_data_o,

   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   output logic [15:0]           ctrl_lines_o
);

   wb_if m_bus ();
   wb_if s0_bus ();
   wb_if s1_bus ();
   wb_if s2_bus ();

   assign m_bus.adr      = m_adr_i;
   assign m_bus.dat_mosi = m_dat_i;
   assign m_bus.sel      = m_sel_i;
   assign m_bus.we       = m_we_i;
   assign m_bus.cyc      = m_cyc_i;
   assign m_bus.stb      = m_stb_i;
   assign m_dat_o        = m_bus.dat_miso;
   assign m_ack_o        = m_bus.ack;

   //////////////////////////////////////////////////
   // Intercon and slaves
   //////////////////////////////////////////////////

   wb_1master intercon
   (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .m (m_bus.slave), .s0 (s0_bus.master), .s1 (s1_bus.master), .s2 (s2_bus.master)
   );

   misc_regs misc_regs   // Slave 0
   (
      .wb_clk (wb_clk), .wb_rst (wb_rst), .bus (s0_bus.slave),
      .debug_pb_i (debug_pb_i), .dip_sw_i (dip_sw_i),
      .cgen_st_status_i (cgen_st_status_i), .cgen_st_ld_i (cgen_st_ld_i),
      .cgen_st_refmon_i (cgen_st_refmon_i), .debug_led_o (debug_led_o),
      .cgen_sync_b_o (cgen_sync_b_o), .cgen_ref_sel_o (cgen_ref_sel_o),
      .tx_underrun_o (tx_underrun_o), .rx_overrun_o (rx_overrun_o)
   );

   settings_bus_16le settings_bus   // Slave 1
   (
      .wb_clk (wb_clk), .wb_rst (wb_rst), .bus (s1_bus.slave),
      .set_stb_o (set_stb_o), .set_addr_o (set_addr_o), .set_data_o (set_data_o)
   );

   atr_controller16 atr   // Slave 2
   (
      .wb_clk (wb_clk), .wb_rst (wb_rst), .bus (s2_bus.slave),
      .run_rx_i (run_rx_i), .run_tx_i (run_tx_i), .ctrl_lines_o (ctrl_lines_o)
   );

endmodule

// ==== tb_u1e_core.sv ====
`timescale 1ns/1ns

module tb_u1e_core;

   logic        wb_clk = 1'b0;
   logic        wb_rst;
   logic [10:0] m_adr_i;
   logic [15:0] m_dat_i;
   logic [15:0] m_dat_o;
   logic [1:0]  m_sel_i;
   logic        m_we_i, m_cyc_i, m_stb_i, m_ack_o;
   logic [2:0]  debug_pb_i;
   logic [7:0]  dip_sw_i;
   logic        cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i;
   logic [2:0]  debug_led_o;
   logic        cgen_sync_b_o, cgen_ref_sel_o, tx_underrun_o, rx_overrun_o;
   logic        set_stb_o;
   logic [7:0]  set_addr_o;
   logic [31:0] set_data_o;
   logic        run_rx_i, run_tx_i;
   logic [15:0] ctrl_lines_o;

   byte         ops [$];          // Opcode per data line
   logic [31:0] fa [$], fb [$], fc [$];
   logic [31:0] lfsr        = 32'h55f058de;
   int          cycle_count = 0;
   int          cycle_limit = 0;   // Set once the data file is loaded

   always #20 wb_clk = ~wb_clk;

   u1e_core dut (.*);

   always @(posedge wb_clk)
   begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count >= cycle_limit)
      begin
         $display("Timeout: the bus tests did not finish within %0d cycles", cycle_limit);
         $display("Regression failed");
         $fatal(1);
      end
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("Regression failed");
         $fatal(1);
      end
   endtask

   // Fibonacci taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic next_edge();
      @(posedge wb_clk);
      #5;                          // Drive and sample point
   endtask

   // 0 to 3 idle cycles, two LFSR bits
   task automatic idle_gap();
      logic [1:0] gap;
      for (int i = 0; i < 2; i++)
      begin
         lfsr = lfsr_next(lfsr);
         gap  = {gap[0], lfsr[0]};
      end
      repeat (gap) next_edge();
   endtask

   task automatic bus_access(input logic we, input logic [10:0] adr, input logic [15:0] dat,
                             input logic [1:0] sel, output logic [15:0] rdata,
                             output logic stb_seen, output logic [7:0] set_addr_seen,
                             output logic [31:0] set_data_seen);
      int waited;
      idle_gap();
      check_value("m_ack_o", m_ack_o, 0);
      waited  = 0;
      m_adr_i = adr;
      m_dat_i = dat;
      m_sel_i = sel;
      m_we_i  = we;
      m_cyc_i = 1'b1;
      m_stb_i = 1'b1;
      do
      begin
         next_edge();
         waited++;
      end
      while (!m_ack_o);
      rdata         = m_dat_o;     // Valid in the ack cycle
      stb_seen      = set_stb_o;
      set_addr_seen = set_addr_o;  // Settings word travels with the strobe
      set_data_seen = set_data_o;
      m_cyc_i       = 1'b0;
      m_stb_i       = 1'b0;
      m_we_i        = 1'b0;
      check_value("m_ack_o latency", waited, 1);
      next_edge();                 // Ack drops before the next request
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   initial
   begin
      int          fd;
      string       line;
      byte         op;
      logic [31:0] a, b, c;
      logic [15:0] rdata;
      logic        stb_seen;
      logic [7:0]  set_addr_seen;
      logic [31:0] set_data_seen;
      wb_rst           = 1'b1;
      m_adr_i          = '0;
      m_dat_i          = '0;
      m_sel_i          = '0;
      m_we_i           = 1'b0;
      m_cyc_i          = 1'b0;
      m_stb_i          = 1'b0;
      debug_pb_i       = '0;
      dip_sw_i         = '0;
      cgen_st_status_i = 1'b0;
      cgen_st_ld_i     = 1'b0;
      cgen_st_refmon_i = 1'b0;
      run_rx_i         = 1'b0;
      run_tx_i         = 1'b0;

      fd = $fopen("u1e_core_input.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the stimulus file u1e_core_input.txt");
         $display("Regression failed");
         $fatal(1);
      end
      while ($fgets(line, fd))
         if ($sscanf(line, "%c %h %h %h", op, a, b, c) == 4 && op != "#")
         begin
            ops.push_back(op);
            fa.push_back(a);
            fb.push_back(b);
            fc.push_back(c);
         end
      $fclose(fd);
      cycle_limit = 20 * ops.size() + 100;

      repeat (10) @(posedge wb_clk);
      #5;
      wb_rst = 1'b0;

      // Outputs straight out of reset
      check_value("cgen_sync_b_o", cgen_sync_b_o, 1);
      check_value("cgen_ref_sel_o", cgen_ref_sel_o, 1);
      check_value("debug_led_o", debug_led_o, 0);
      check_value("tx_underrun_o", tx_underrun_o, 0);
      check_value("rx_overrun_o", rx_overrun_o, 0);
      check_value("set_stb_o", set_stb_o, 0);
      check_value("set_addr_o", set_addr_o, 0);
      check_value("set_data_o", set_data_o, 0);
      check_value("ctrl_lines_o", ctrl_lines_o, 0);
      check_value("m_ack_o", m_ack_o, 0);
      check_value("m_dat_o", m_dat_o, 0);

      foreach (ops[i])
         case (ops[i])
            "W":
            begin
               bus_access(1'b1, fa[i][10:0], fb[i][15:0], fc[i][1:0], rdata, stb_seen,
                          set_addr_seen, set_data_seen);
               check_value("set_stb_o", stb_seen, 0);
            end
            "R":
            begin
               bus_access(1'b0, fa[i][10:0], 16'h0, 2'b11, rdata, stb_seen,
                          set_addr_seen, set_data_seen);
               check_value("m_dat_o", rdata, fb[i]);
               check_value("set_stb_o", stb_seen, 0);
            end
            "S":
            begin
               bus_access(1'b1, fa[i][10:0], fc[i][31:16], 2'b11, rdata, stb_seen,
                          set_addr_seen, set_data_seen);
               check_value("set_stb_o", stb_seen, 1);
               check_value("set_addr_o", set_addr_seen, fb[i]);
               check_value("set_data_o", set_data_seen, fc[i]);
               check_value("set_stb_o", set_stb_o, 0);   // Single pulse only
            end
            "A":
            begin
               {run_tx_i, run_rx_i} = fa[i][1:0];
               next_edge();
               check_value("ctrl_lines_o", ctrl_lines_o, fb[i]);
            end
            "P":
            begin
               {debug_pb_i, dip_sw_i} = fa[i][10:0];
               {cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i} = fb[i][2:0];
               next_edge();
            end
            "O":
            begin
               check_value("debug_led_o", debug_led_o, fa[i]);
               check_value("cgen_sync_b_o/cgen_ref_sel_o", {cgen_sync_b_o, cgen_ref_sel_o}, fb[i]);
               check_value("rx_overrun_o/tx_underrun_o", {rx_overrun_o, tx_underrun_o}, fc[i]);
            end
            default:
            begin
               $display("The stimulus file holds an unknown opcode on entry %0d", i);
               $display("Regression failed");
               $fatal(1);
            end
         endcase

      $display("Regression passed");
      $finish;
   end

endmodule

// ==== u1e_core_input.txt ====
# op a b c in hex. W: adr data sel. R: adr expected 0. S: adr set_addr set_data
# A: run {tx,rx} lines 0. P: {pb,dip} {status,ld,refmon} 0. O: leds {sync_b,ref_sel} {rx,tx}
W 000 0005 3
R 000 0005 0
O 6 3 0
W 004 0001 3
W 008 0002 3
R 004 0001 0
R 008 0002 0
O 6 1 2
P 5a3 5 0
R 002 05a3 0
R 006 0005 0
R 00c beef 0
W 094 1234 3
S 096 05 abcd1234
W 0fc 5678 3
S 0fe 1f 9abc5678
W 100 1111 3
W 102 2222 3
W 104 4444 3
W 106 ffff 3
W 106 0088 1
R 102 2222 0
R 106 ff88 0
A 0 1111 0
A 1 2222 0
A 2 4444 0
A 3 ff88 0
R 480 0000 0

// ==== u1e_core.f ====
+incdir+.
u1e_pkg.sv
wb_if.sv
wb_1master.sv
misc_regs.sv
settings_bus_16le.sv
atr_controller16.sv
u1e_core.sv
tb_u1e_core.sv

// ==== Bender.yml ====
package:
  name: u1e_core

sources:
  - include_dirs:
      - .
    files:
      - u1e_pkg.sv
      - wb_if.sv
      - wb_1master.sv
      - misc_regs.sv
      - settings_bus_16le.sv
      - atr_controller16.sv
      - u1e_core.sv
      - tb_u1e_core.sv
